//--- Bender.yml
package:
  name: axi_rd_node

sources:
  - xbar_pkg.sv
  - xbar_if.sv
  - ar_decoder.sv
  - rr_arbiter.sv
  - decerr_beat_counter.sv
  - decerr_fsm.sv
  - target_port.sv
  - initiator_r_mux.sv
  - axi_rd_node.sv
  - target: test
    files:
      - tb_target_model.sv
      - tb_axi_rd_node.sv

//--- ar_decoder.sv
module ar_decoder #(
	parameter int N_TARG = xbar_pkg::N_TARG,
	parameter int N_REGION = xbar_pkg::N_REGION,
	parameter int INIT_IDX = 0
) (
	input  xbar_pkg::addr_t   araddr_i,
	input  xbar_pkg::len_t    arlen_i,
	input  xbar_pkg::id_in_t  arid_i,
	input  logic              arvalid_i,
	output logic              arready_o,
	input  xbar_pkg::addr_t   cfg_start_addr_i [N_TARG][N_REGION],
	input  xbar_pkg::addr_t   cfg_end_addr_i [N_TARG][N_REGION],
	input  logic [N_REGION-1:0] cfg_valid_rule_i [N_TARG],
	input  logic [N_TARG-1:0] connectivity_i,
	ar_route_if.init          ar_o,
	output logic              miss_o,
	input  logic              accept_i
);
	import xbar_pkg::*;

	logic [N_TARG-1:0] hit;
	logic [N_TARG-1:0] req;

	// Region match, then masked by the connectivity of this initiator.
	always_comb begin
		hit = '0;
		for (int t = 0; t < N_TARG; t++) begin
			for (int r = 0; r < N_REGION; r++) begin
				if (cfg_valid_rule_i[t][r] &&
				    araddr_i >= cfg_start_addr_i[t][r] &&
				    araddr_i <= cfg_end_addr_i[t][r]) begin
					hit[t] = 1'b1;
				end
			end
		end
		hit = hit & connectivity_i;
	end

	assign req = arvalid_i ? hit : '0;
	assign miss_o = arvalid_i && (hit == '0);

	assign ar_o.req = req;
	assign ar_o.addr = araddr_i;
	assign ar_o.len = arlen_i;
	assign ar_o.id = {IDX_W'(INIT_IDX), arid_i};

	assign arready_o = (|(req & ar_o.gnt)) | accept_i;

	// Overlapping enabled regions of two connected targets.
	always_comb begin
		if (arvalid_i) begin
			assert final ($onehot0(hit))
				else $error("ar_decoder %0d: address hits more than one target", INIT_IDX);
		end
	end

endmodule

//--- axi_rd_node.f
xbar_pkg.sv
xbar_if.sv
ar_decoder.sv
rr_arbiter.sv
decerr_beat_counter.sv
decerr_fsm.sv
target_port.sv
initiator_r_mux.sv
axi_rd_node.sv
tb_target_model.sv
tb_axi_rd_node.sv

//--- axi_rd_node.sv
module axi_rd_node #(
	parameter int N_INIT = xbar_pkg::N_INIT,
	parameter int N_TARG = xbar_pkg::N_TARG,
	parameter int N_REGION = xbar_pkg::N_REGION
) (
	input  logic                clk,
	input  logic                arst_n_i,

	input  xbar_pkg::id_in_t    init_arid_i [N_INIT],
	input  xbar_pkg::addr_t     init_araddr_i [N_INIT],
	input  xbar_pkg::len_t      init_arlen_i [N_INIT],
	input  logic [N_INIT-1:0]   init_arvalid_i,
	output logic [N_INIT-1:0]   init_arready_o,
	output xbar_pkg::id_in_t    init_rid_o [N_INIT],
	output xbar_pkg::data_t     init_rdata_o [N_INIT],
	output xbar_pkg::resp_t     init_rresp_o [N_INIT],
	output logic [N_INIT-1:0]   init_rlast_o,
	output logic [N_INIT-1:0]   init_rvalid_o,
	input  logic [N_INIT-1:0]   init_rready_i,

	output xbar_pkg::id_out_t   targ_arid_o [N_TARG],
	output xbar_pkg::addr_t     targ_araddr_o [N_TARG],
	output xbar_pkg::len_t      targ_arlen_o [N_TARG],
	output logic [N_TARG-1:0]   targ_arvalid_o,
	input  logic [N_TARG-1:0]   targ_arready_i,
	input  xbar_pkg::id_out_t   targ_rid_i [N_TARG],
	input  xbar_pkg::data_t     targ_rdata_i [N_TARG],
	input  xbar_pkg::resp_t     targ_rresp_i [N_TARG],
	input  logic [N_TARG-1:0]   targ_rlast_i,
	input  logic [N_TARG-1:0]   targ_rvalid_i,
	output logic [N_TARG-1:0]   targ_rready_o,

	input  xbar_pkg::addr_t     cfg_start_addr_i [N_TARG][N_REGION],
	input  xbar_pkg::addr_t     cfg_end_addr_i [N_TARG][N_REGION],
	input  logic [N_REGION-1:0] cfg_valid_rule_i [N_TARG],
	input  logic [N_TARG-1:0]   cfg_connectivity_map_i [N_INIT]
);
	import xbar_pkg::*;

	logic [N_INIT-1:0] miss;
	logic [N_INIT-1:0] accept;
	logic [N_INIT-1:0] err_valid;
	logic [N_INIT-1:0] err_last;
	logic [N_INIT-1:0] err_ready;
	id_in_t err_id [N_INIT];

	ar_route_if #(.N_TARG(N_TARG)) ar_bus [N_INIT] ();
	r_route_if #(.N_INIT(N_INIT)) r_bus [N_TARG] ();

	for (genvar i = 0; i < N_INIT; i++) begin : g_init
		ar_decoder #(
			.N_TARG   (N_TARG),
			.N_REGION (N_REGION),
			.INIT_IDX (i)
		) u_dec (
			.araddr_i         (init_araddr_i[i]),
			.arlen_i          (init_arlen_i[i]),
			.arid_i           (init_arid_i[i]),
			.arvalid_i        (init_arvalid_i[i]),
			.arready_o        (init_arready_o[i]),
			.cfg_start_addr_i (cfg_start_addr_i),
			.cfg_end_addr_i   (cfg_end_addr_i),
			.cfg_valid_rule_i (cfg_valid_rule_i),
			.connectivity_i   (cfg_connectivity_map_i[i]),
			.ar_o             (ar_bus[i]),
			.miss_o           (miss[i]),
			.accept_i         (accept[i])
		);

		decerr_fsm u_fsm (
			.clk         (clk),
			.arst_n_i    (arst_n_i),
			.miss_i      (miss[i]),
			.arid_i      (init_arid_i[i]),
			.arlen_i     (init_arlen_i[i]),
			.accept_o    (accept[i]),
			.err_valid_o (err_valid[i]),
			.err_id_o    (err_id[i]),
			.err_last_o  (err_last[i]),
			.err_ready_i (err_ready[i])
		);

		initiator_r_mux #(
			.N_TARG   (N_TARG),
			.INIT_IDX (i)
		) u_rmux (
			.clk         (clk),
			.arst_n_i    (arst_n_i),
			.r_i         (r_bus),
			.err_valid_i (err_valid[i]),
			.err_id_i    (err_id[i]),
			.err_last_i  (err_last[i]),
			.err_ready_o (err_ready[i]),
			.rid_o       (init_rid_o[i]),
			.rdata_o     (init_rdata_o[i]),
			.rresp_o     (init_rresp_o[i]),
			.rlast_o     (init_rlast_o[i]),
			.rvalid_o    (init_rvalid_o[i]),
			.rready_i    (init_rready_i[i])
		);
	end

	for (genvar t = 0; t < N_TARG; t++) begin : g_targ
		target_port #(
			.N_INIT   (N_INIT),
			.TARG_IDX (t)
		) u_targ (
			.clk       (clk),
			.arst_n_i  (arst_n_i),
			.ar_i      (ar_bus),
			.arid_o    (targ_arid_o[t]),
			.araddr_o  (targ_araddr_o[t]),
			.arlen_o   (targ_arlen_o[t]),
			.arvalid_o (targ_arvalid_o[t]),
			.arready_i (targ_arready_i[t]),
			.rid_i     (targ_rid_i[t]),
			.rdata_i   (targ_rdata_i[t]),
			.rresp_i   (targ_rresp_i[t]),
			.rlast_i   (targ_rlast_i[t]),
			.rvalid_i  (targ_rvalid_i[t]),
			.rready_o  (targ_rready_o[t]),
			.r_o       (r_bus[t])
		);
	end

endmodule

//--- decerr_beat_counter.sv
module decerr_beat_counter (
	input  logic           clk,
	input  logic           arst_n_i,
	input  logic           load_i,
	input  xbar_pkg::len_t len_i,
	input  logic           dec_i,
	output logic           last_o
);
	import xbar_pkg::*;

	len_t count_q;

	// Beats still to come after the current one.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			count_q <= '0;
		end else if (load_i) begin
			count_q <= len_i;
		end else if (dec_i && count_q != '0) begin
			count_q <= count_q - 1'b1;
		end
	end

	assign last_o = (count_q == '0);

endmodule

//--- decerr_fsm.sv
module decerr_fsm (
	input  logic             clk,
	input  logic             arst_n_i,
	input  logic             miss_i,
	input  xbar_pkg::id_in_t arid_i,
	input  xbar_pkg::len_t   arlen_i,
	output logic             accept_o,
	output logic             err_valid_o,
	output xbar_pkg::id_in_t err_id_o,
	output logic             err_last_o,
	input  logic             err_ready_i
);
	typedef enum logic {
		IDLE,
		RESP
	} state_e;

	state_e state_q;
	state_e state_d;
	logic beat_fire;
	logic cnt_last;

	assign accept_o = (state_q == IDLE) && miss_i;
	assign err_valid_o = (state_q == RESP);
	assign beat_fire = err_valid_o && err_ready_i;
	assign err_last_o = cnt_last;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (accept_o) begin
					state_d = RESP;
				end
			end
			RESP: begin
				if (beat_fire && cnt_last) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge clk) begin
		if (accept_o) begin
			err_id_o <= arid_i;
		end
	end

	decerr_beat_counter u_cnt (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.load_i   (accept_o),
		.len_i    (arlen_i),
		.dec_i    (beat_fire),
		.last_o   (cnt_last)
	);

	assert property (@(posedge clk) disable iff (!arst_n_i)
		err_valid_o && !err_ready_i |=> err_valid_o && $stable(err_id_o) && $stable(err_last_o))
		else $error("decerr_fsm: error beat dropped before it was taken");

endmodule

//--- initiator_r_mux.sv
module initiator_r_mux #(
	parameter int N_TARG = xbar_pkg::N_TARG,
	parameter int INIT_IDX = 0
) (
	input  logic             clk,
	input  logic             arst_n_i,
	r_route_if.init          r_i [N_TARG],
	input  logic             err_valid_i,
	input  xbar_pkg::id_in_t err_id_i,
	input  logic             err_last_i,
	output logic             err_ready_o,
	output xbar_pkg::id_in_t rid_o,
	output xbar_pkg::data_t  rdata_o,
	output xbar_pkg::resp_t  rresp_o,
	output logic             rlast_o,
	output logic             rvalid_o,
	input  logic             rready_i
);
	import xbar_pkg::*;

	// Targets first, the error responder takes the last slot.
	localparam int N_SRC = N_TARG + 1;

	logic [N_SRC-1:0] src_valid;
	logic [N_SRC-1:0] src_last;
	logic [N_SRC-1:0] gnt;
	data_t src_data [N_SRC];
	resp_t src_resp [N_SRC];
	id_in_t src_id [N_SRC];
	logic beat_fire;
	logic locked_q;
	logic stall_q;

	for (genvar t = 0; t < N_TARG; t++) begin : g_targ
		assign src_valid[t] = r_i[t].valid[INIT_IDX];
		assign src_last[t] = r_i[t].last;
		assign src_data[t] = r_i[t].data;
		assign src_resp[t] = r_i[t].resp;
		assign src_id[t] = r_i[t].id;
		assign r_i[t].ready[INIT_IDX] = gnt[t] & rready_i;
	end

	assign src_valid[N_TARG] = err_valid_i;
	assign src_last[N_TARG] = err_last_i;
	assign src_data[N_TARG] = '0;
	assign src_resp[N_TARG] = RESP_DECERR;
	assign src_id[N_TARG] = err_id_i;
	assign err_ready_o = gnt[N_TARG] & rready_i;

	rr_arbiter #(
		.N (N_SRC)
	) u_arb (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.req_i    (src_valid),
		.lock_i   (locked_q | stall_q),
		.fire_i   (beat_fire),
		.gnt_o    (gnt)
	);

	always_comb begin
		rid_o = '0;
		rdata_o = '0;
		rresp_o = '0;
		rlast_o = 1'b0;
		for (int s = 0; s < N_SRC; s++) begin
			if (gnt[s]) begin
				rid_o = src_id[s];
				rdata_o = src_data[s];
				rresp_o = src_resp[s];
				rlast_o = src_last[s];
			end
		end
	end

	assign rvalid_o = |gnt;
	assign beat_fire = rvalid_o && rready_i;

	// Burst stays on one source until its last beat is taken.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			locked_q <= 1'b0;
		end else if (beat_fire) begin
			locked_q <= !rlast_o;
		end
	end

	// A beat shown but not taken keeps its source.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			stall_q <= 1'b0;
		end else begin
			stall_q <= rvalid_o && !rready_i;
		end
	end

endmodule

//--- rr_arbiter.sv
module rr_arbiter #(
	parameter int N = 2
) (
	input  logic         clk,
	input  logic         arst_n_i,
	input  logic [N-1:0] req_i,
	input  logic         lock_i,
	input  logic         fire_i,
	output logic [N-1:0] gnt_o
);
	localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

	logic [PTR_W-1:0] ptr_q;
	logic [PTR_W-1:0] win_idx;
	logic [N-1:0] gnt_rr;
	logic [N-1:0] gnt_q;

	// First requester at or after the pointer wins.
	always_comb begin
		int idx;
		logic found;
		gnt_rr = '0;
		found = 1'b0;
		for (int k = 0; k < N; k++) begin
			idx = (int'(ptr_q) + k) % N;
			if (!found && req_i[idx]) begin
				gnt_rr[idx] = 1'b1;
				found = 1'b1;
			end
		end
	end

	// Held grant while locked.
	assign gnt_o = (lock_i ? gnt_q : gnt_rr) & req_i;

	always_comb begin
		win_idx = '0;
		for (int k = 0; k < N; k++) begin
			if (gnt_o[k]) begin
				win_idx = PTR_W'(k);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ptr_q <= '0;
			gnt_q <= '0;
		end else begin
			if (!lock_i) begin
				gnt_q <= gnt_rr;
			end
			if (fire_i) begin
				ptr_q <= (int'(win_idx) == N - 1) ? '0 : win_idx + 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n_i) $onehot0(gnt_o))
		else $error("rr_arbiter: grant is not one-hot");

endmodule

//--- target_port.sv
module target_port #(
	parameter int N_INIT = xbar_pkg::N_INIT,
	parameter int TARG_IDX = 0
) (
	input  logic              clk,
	input  logic              arst_n_i,
	ar_route_if.targ          ar_i [N_INIT],
	output xbar_pkg::id_out_t arid_o,
	output xbar_pkg::addr_t   araddr_o,
	output xbar_pkg::len_t    arlen_o,
	output logic              arvalid_o,
	input  logic              arready_i,
	input  xbar_pkg::id_out_t rid_i,
	input  xbar_pkg::data_t   rdata_i,
	input  xbar_pkg::resp_t   rresp_i,
	input  logic              rlast_i,
	input  logic              rvalid_i,
	output logic              rready_o,
	r_route_if.targ           r_o
);
	import xbar_pkg::*;

	logic [N_INIT-1:0] req;
	logic [N_INIT-1:0] gnt;
	logic [N_INIT-1:0] r_valid;
	logic [N_INIT-1:0] r_ready;
	addr_t req_addr [N_INIT];
	len_t req_len [N_INIT];
	id_out_t req_id [N_INIT];
	logic ar_fire;
	logic hold_q;

	for (genvar g = 0; g < N_INIT; g++) begin : g_init
		assign req[g] = ar_i[g].req[TARG_IDX];
		assign req_addr[g] = ar_i[g].addr;
		assign req_len[g] = ar_i[g].len;
		assign req_id[g] = ar_i[g].id;
		assign ar_i[g].gnt[TARG_IDX] = gnt[g] & arready_i;
		assign r_valid[g] = rvalid_i && (rid_i[ID_OUT_W-1 -: IDX_W] == IDX_W'(g));
		assign r_ready[g] = r_o.ready[g];
	end

	assign arvalid_o = |gnt;
	assign ar_fire = arvalid_o && arready_i;

	always_comb begin
		araddr_o = '0;
		arlen_o = '0;
		arid_o = '0;
		for (int g = 0; g < N_INIT; g++) begin
			if (gnt[g]) begin
				araddr_o = req_addr[g];
				arlen_o = req_len[g];
				arid_o = req_id[g];
			end
		end
	end

	// A request shown but not taken keeps its grant.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			hold_q <= 1'b0;
		end else begin
			hold_q <= arvalid_o && !arready_i;
		end
	end

	rr_arbiter #(
		.N (N_INIT)
	) u_arb (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.req_i    (req),
		.lock_i   (hold_q),
		.fire_i   (ar_fire),
		.gnt_o    (gnt)
	);

	assign r_o.valid = r_valid;
	assign r_o.data = rdata_i;
	assign r_o.resp = rresp_i;
	assign r_o.last = rlast_i;
	assign r_o.id = rid_i[ID_IN_W-1:0];
	assign rready_o = |(r_valid & r_ready);

	assert property (@(posedge clk) disable iff (!arst_n_i)
		arvalid_o && !arready_i |=> arvalid_o && $stable(arid_o) && $stable(araddr_o))
		else $error("target_port %0d: AR payload changed under back-pressure", TARG_IDX);

endmodule

//--- tb_axi_rd_node.sv
module tb_axi_rd_node;
	timeunit 1ns;
	timeprecision 1ps;
	import xbar_pkg::*;

	localparam int N_ID = 2 ** ID_IN_W;

	typedef struct packed {
		data_t data;
		resp_t resp;
		id_in_t id;
		logic last;
	} beat_t;

	logic clk = 1'b0;
	logic arst_n;
	id_in_t init_arid [N_INIT];
	addr_t init_araddr [N_INIT];
	len_t init_arlen [N_INIT];
	logic [N_INIT-1:0] init_arvalid;
	logic [N_INIT-1:0] init_arready;
	id_in_t init_rid [N_INIT];
	data_t init_rdata [N_INIT];
	resp_t init_rresp [N_INIT];
	logic [N_INIT-1:0] init_rlast;
	logic [N_INIT-1:0] init_rvalid;
	logic [N_INIT-1:0] init_rready;
	id_out_t targ_arid [N_TARG];
	addr_t targ_araddr [N_TARG];
	len_t targ_arlen [N_TARG];
	logic [N_TARG-1:0] targ_arvalid;
	logic [N_TARG-1:0] targ_arready;
	id_out_t targ_rid [N_TARG];
	data_t targ_rdata [N_TARG];
	resp_t targ_rresp [N_TARG];
	logic [N_TARG-1:0] targ_rlast;
	logic [N_TARG-1:0] targ_rvalid;
	logic [N_TARG-1:0] targ_rready;
	addr_t cfg_start [N_TARG][N_REGION];
	addr_t cfg_end [N_TARG][N_REGION];
	logic [N_REGION-1:0] cfg_valid [N_TARG];
	logic [N_TARG-1:0] cfg_conn [N_INIT];

	logic [N_TARG-1:0] ar_stall;
	logic [N_TARG-1:0] r_gap;
	logic [31:0] lfsr = 32'h40b7;
	logic bp_on;
	string test_name;
	int cycles = 0;
	int cycle_limit;
	int beats_done;

	// Request list, one entry per burst.
	int rq_test [$];
	int rq_init [$];
	addr_t rq_addr [$];
	len_t rq_len [$];
	id_in_t rq_id [$];
	int next_id [N_INIT];

	logic issued [N_INIT][N_ID];
	logic answered [N_INIT][N_ID];
	addr_t pend_addr [N_INIT][N_ID];
	len_t pend_len [N_INIT][N_ID];
	logic in_burst [N_INIT];
	id_in_t cur_id [N_INIT];
	int beat_k [N_INIT];

	axi_rd_node #(
		.N_INIT   (N_INIT),
		.N_TARG   (N_TARG),
		.N_REGION (N_REGION)
	) uut (
		.clk                    (clk),
		.arst_n_i               (arst_n),
		.init_arid_i            (init_arid),
		.init_araddr_i          (init_araddr),
		.init_arlen_i           (init_arlen),
		.init_arvalid_i         (init_arvalid),
		.init_arready_o         (init_arready),
		.init_rid_o             (init_rid),
		.init_rdata_o           (init_rdata),
		.init_rresp_o           (init_rresp),
		.init_rlast_o           (init_rlast),
		.init_rvalid_o          (init_rvalid),
		.init_rready_i          (init_rready),
		.targ_arid_o            (targ_arid),
		.targ_araddr_o          (targ_araddr),
		.targ_arlen_o           (targ_arlen),
		.targ_arvalid_o         (targ_arvalid),
		.targ_arready_i         (targ_arready),
		.targ_rid_i             (targ_rid),
		.targ_rdata_i           (targ_rdata),
		.targ_rresp_i           (targ_rresp),
		.targ_rlast_i           (targ_rlast),
		.targ_rvalid_i          (targ_rvalid),
		.targ_rready_o          (targ_rready),
		.cfg_start_addr_i       (cfg_start),
		.cfg_end_addr_i         (cfg_end),
		.cfg_valid_rule_i       (cfg_valid),
		.cfg_connectivity_map_i (cfg_conn)
	);

	for (genvar t = 0; t < N_TARG; t++) begin : g_targ
		tb_target_model u_model (
			.clk        (clk),
			.arst_n_i   (arst_n),
			.ar_stall_i (ar_stall[t]),
			.r_gap_i    (r_gap[t]),
			.arid_i     (targ_arid[t]),
			.araddr_i   (targ_araddr[t]),
			.arlen_i    (targ_arlen[t]),
			.arvalid_i  (targ_arvalid[t]),
			.arready_o  (targ_arready[t]),
			.rid_o      (targ_rid[t]),
			.rdata_o    (targ_rdata[t]),
			.rresp_o    (targ_rresp[t]),
			.rlast_o    (targ_rlast[t]),
			.rvalid_o   (targ_rvalid[t]),
			.rready_i   (targ_rready[t])
		);
	end

	always #2 clk = ~clk;

	// Taps 32, 22, 2 and 1.
	function automatic logic take_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic int take_bits(int n);
		int v;
		v = 0;
		for (int b = 0; b < n; b++) begin
			v = (v << 1) | int'(take_bit());
		end
		return v;
	endfunction

	// Target that an initiator's address should reach, or -1 for a decode error.
	function automatic int expected_target(int init, addr_t addr);
		int hit;
		hit = -1;
		for (int t = 0; t < N_TARG; t++) begin
			for (int r = 0; r < N_REGION; r++) begin
				if (cfg_valid[t][r] && cfg_conn[init][t] &&
				    addr >= cfg_start[t][r] && addr <= cfg_end[t][r]) begin
					hit = t;
				end
			end
		end
		return hit;
	endfunction

	function automatic beat_t expected_beat(int init, addr_t addr, len_t len, id_in_t id, int k);
		beat_t b;
		b.id = id;
		b.last = (k == int'(len));
		if (expected_target(init, addr) >= 0) begin
			b.data = addr + data_t'(4 * k);
			b.resp = RESP_OKAY;
		end else begin
			b.data = '0;
			b.resp = RESP_DECERR;
		end
		return b;
	endfunction

	task automatic abort_run(string why);
		$display("TEST FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_data(string name, data_t exp, data_t act);
		if (act !== exp) begin
			$display("ERROR %s: rdata expected %h actual %h", name, exp, act);
			abort_run("read data mismatch");
		end
	endtask

	task automatic check_resp(string name, resp_t exp, resp_t act);
		if (act !== exp) begin
			$display("ERROR %s: rresp expected %h actual %h", name, exp, act);
			abort_run("read response mismatch");
		end
	endtask

	task automatic check_id(string name, id_in_t exp, id_in_t act);
		if (act !== exp) begin
			$display("ERROR %s: rid expected %h actual %h", name, exp, act);
			abort_run("read ID mismatch");
		end
	endtask

	task automatic check_last(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("ERROR %s: rlast expected %b actual %b", name, exp, act);
			abort_run("rlast mismatch");
		end
	endtask

	task automatic check_target(string name, int exp, int act);
		if (act != exp) begin
			$display("ERROR %s: request target expected %0d actual %0d", name, exp, act);
			abort_run("request reached the wrong target");
		end
	endtask

	task automatic check_beat(int i);
		beat_t exp;
		if (!in_burst[i] && !(issued[i][init_rid[i]] && !answered[i][init_rid[i]])) begin
			$display("Initiator %0d received a beat with ID %0h that no open request has",
				i, init_rid[i]);
			abort_run("unexpected read beat");
		end else begin
			if (!in_burst[i]) begin
				in_burst[i] = 1'b1;
				cur_id[i] = init_rid[i];
				beat_k[i] = 0;
			end
			exp = expected_beat(i, pend_addr[i][cur_id[i]], pend_len[i][cur_id[i]],
				cur_id[i], beat_k[i]);
			check_id(test_name, exp.id, init_rid[i]);
			check_data(test_name, exp.data, init_rdata[i]);
			check_resp(test_name, exp.resp, init_rresp[i]);
			check_last(test_name, exp.last, init_rlast[i]);
			beat_k[i]++;
			beats_done++;
			if (exp.last) begin
				in_burst[i] = 1'b0;
				answered[i][cur_id[i]] = 1'b1;
			end
		end
	endtask

	task automatic add_req(int t, int i, addr_t addr, len_t len);
		rq_test.push_back(t);
		rq_init.push_back(i);
		rq_addr.push_back(addr);
		rq_len.push_back(len);
		rq_id.push_back(id_in_t'(next_id[i]));
		next_id[i] = (next_id[i] + 1) % N_ID;
		cycle_limit += 40 * (int'(len) + 1);
	endtask

	task automatic build_requests();
		// Target 0 holds 0x0000_xxxx, target 1 holds 0x1000_xxxx and 0x2000_xxxx.
		add_req(1, 0, 32'h0000_0100, 8'd3);
		add_req(1, 0, 32'h1000_0040, 8'd0);
		add_req(1, 1, 32'h0000_8000, 8'd7);
		add_req(1, 0, 32'h2000_0010, 8'd2);
		// Disabled region, unmapped addresses and a disconnected target.
		add_req(2, 0, 32'h0001_0010, 8'd2);
		add_req(2, 1, 32'h3000_0000, 8'd4);
		add_req(2, 1, 32'h1000_0020, 8'd1);
		add_req(2, 0, 32'h8000_0000, 8'd0);
		for (int n = 0; n < 2; n++) begin
			add_req(3, 0, 32'h0000_1000 + addr_t'(n * 256), 8'd7);
			add_req(3, 1, 32'h0000_2000 + addr_t'(n * 256), 8'd7);
		end
		add_req(4, 0, 32'h1000_0200, 8'd5);
		add_req(4, 0, 32'h0000_0300, 8'd3);
		add_req(4, 1, 32'h0000_0400, 8'd6);
		add_req(4, 1, 32'h0005_0000, 8'd2);
		for (int n = 0; n < 6; n++) begin
			add_req(5, 0, 32'h1000_0000 + addr_t'(take_bits(10) << 2), len_t'(take_bits(4)));
			add_req(5, 1, addr_t'(take_bits(10) << 2), len_t'(take_bits(4)));
		end
	endtask

	task automatic drive_init(int i, int t);
		for (int k = 0; k < rq_test.size(); k++) begin
			if (rq_test[k] == t && rq_init[k] == i) begin
				@(negedge clk);
				issued[i][rq_id[k]] = 1'b1;
				pend_addr[i][rq_id[k]] = rq_addr[k];
				pend_len[i][rq_id[k]] = rq_len[k];
				init_arid[i] = rq_id[k];
				init_araddr[i] = rq_addr[k];
				init_arlen[i] = rq_len[k];
				init_arvalid[i] = 1'b1;
				do begin
					@(posedge clk);
				end while (!init_arready[i]);
			end
		end
		@(negedge clk);
		init_arvalid[i] = 1'b0;
	endtask

	task automatic run_test(int t, string name, logic bp);
		int goal;
		@(posedge clk);
		goal = beats_done;
		for (int k = 0; k < rq_test.size(); k++) begin
			if (rq_test[k] == t) begin
				goal += int'(rq_len[k]) + 1;
			end
		end
		test_name = name;
		bp_on = bp;
		fork
			drive_init(0, t);
			drive_init(1, t);
		join
		wait (beats_done == goal);
	endtask

	// Request list first, then fresh stalls and rready every cycle.
	initial begin
		cycle_limit = 64;
		for (int i = 0; i < N_INIT; i++) begin
			next_id[i] = 0;
		end
		build_requests();
		ar_stall = '1;
		r_gap = '1;
		init_rready = '0;
		forever begin
			@(negedge clk);
			for (int t = 0; t < N_TARG; t++) begin
				ar_stall[t] = take_bit();
				r_gap[t] = take_bit();
			end
			for (int i = 0; i < N_INIT; i++) begin
				init_rready[i] = bp_on ? take_bit() : 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		if (!arst_n) begin
			beats_done = 0;
			for (int i = 0; i < N_INIT; i++) begin
				in_burst[i] = 1'b0;
				cur_id[i] = '0;
				beat_k[i] = 0;
				for (int d = 0; d < N_ID; d++) begin
					answered[i][d] = 1'b0;
				end
			end
		end else begin
			for (int t = 0; t < N_TARG; t++) begin
				if (targ_arvalid[t] && targ_arready[t]) begin
					check_target(test_name,
						expected_target(int'(targ_arid[t][ID_OUT_W-1 -: IDX_W]), targ_araddr[t]), t);
				end
			end
			for (int i = 0; i < N_INIT; i++) begin
				if (init_rvalid[i] && init_rready[i]) begin
					check_beat(i);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run passed %0d cycles during %s", cycle_limit, test_name);
			abort_run("cycle limit reached");
		end
	end

	initial begin
		arst_n = 1'b0;
		bp_on = 1'b0;
		test_name = "reset";
		init_arvalid = '0;
		for (int i = 0; i < N_INIT; i++) begin
			init_arid[i] = '0;
			init_araddr[i] = '0;
			init_arlen[i] = '0;
			for (int d = 0; d < N_ID; d++) begin
				issued[i][d] = 1'b0;
				pend_addr[i][d] = '0;
				pend_len[i][d] = '0;
			end
		end
		cfg_start[0][0] = 32'h0000_0000;
		cfg_end[0][0] = 32'h0000_ffff;
		cfg_start[0][1] = 32'h0001_0000;
		cfg_end[0][1] = 32'h0001_ffff;
		cfg_start[1][0] = 32'h1000_0000;
		cfg_end[1][0] = 32'h1000_ffff;
		cfg_start[1][1] = 32'h2000_0000;
		cfg_end[1][1] = 32'h2000_ffff;
		cfg_valid[0] = 2'b01;
		cfg_valid[1] = 2'b11;
		// Initiator 1 cannot reach target 1.
		cfg_conn[0] = 2'b11;
		cfg_conn[1] = 2'b01;
		repeat (16) @(negedge clk);
		arst_n = 1'b1;
		run_test(1, "region_hit", 1'b0);
		run_test(2, "decode_error", 1'b0);
		run_test(3, "contention", 1'b0);
		run_test(4, "backpressure", 1'b1);
		run_test(5, "random_bursts", 1'b1);
		repeat (20) @(posedge clk);
		$display("TEST OK");
		$finish;
	end

endmodule

//--- tb_target_model.sv
module tb_target_model (
	input  logic              clk,
	input  logic              arst_n_i,
	input  logic              ar_stall_i,
	input  logic              r_gap_i,
	input  xbar_pkg::id_out_t arid_i,
	input  xbar_pkg::addr_t   araddr_i,
	input  xbar_pkg::len_t    arlen_i,
	input  logic              arvalid_i,
	output logic              arready_o,
	output xbar_pkg::id_out_t rid_o,
	output xbar_pkg::data_t   rdata_o,
	output xbar_pkg::resp_t   rresp_o,
	output logic              rlast_o,
	output logic              rvalid_o,
	input  logic              rready_i
);
	timeunit 1ns;
	timeprecision 1ps;
	import xbar_pkg::*;

	addr_t q_addr [$];
	len_t q_len [$];
	id_out_t q_id [$];
	int beat;
	logic hold_q;
	logic stall_q;
	logic gap_q;

	// Handshakes and the random choices of the cycle are taken on the rising edge.
	always @(posedge clk) begin
		if (!arst_n_i) begin
			q_addr.delete();
			q_len.delete();
			q_id.delete();
			beat = 0;
			hold_q = 1'b0;
		end else begin
			if (arvalid_i && arready_o) begin
				q_addr.push_back(araddr_i);
				q_len.push_back(arlen_i);
				q_id.push_back(arid_i);
			end
			hold_q = rvalid_o && !rready_i;
			if (rvalid_o && rready_i) begin
				if (beat == int'(q_len[0])) begin
					void'(q_addr.pop_front());
					void'(q_len.pop_front());
					void'(q_id.pop_front());
					beat = 0;
				end else begin
					beat++;
				end
			end
		end
		stall_q = ar_stall_i;
		gap_q = r_gap_i;
	end

	// Bursts are answered in the order they were accepted.
	initial begin
		arready_o = 1'b0;
		rid_o = '0;
		rdata_o = '0;
		rresp_o = '0;
		rlast_o = 1'b0;
		rvalid_o = 1'b0;
		forever begin
			@(negedge clk);
			if (!arst_n_i) begin
				arready_o = 1'b0;
				rvalid_o = 1'b0;
			end else begin
				arready_o = !stall_q;
				if (q_addr.size() > 0 && (hold_q || !gap_q)) begin
					rvalid_o = 1'b1;
					rid_o = q_id[0];
					rdata_o = q_addr[0] + data_t'(4 * beat);
					rresp_o = RESP_OKAY;
					rlast_o = (beat == int'(q_len[0]));
				end else begin
					rvalid_o = 1'b0;
				end
			end
		end
	end

endmodule

//--- xbar_if.sv
// Read address request from one initiator towards all targets.
interface ar_route_if #(
	parameter int N_TARG = xbar_pkg::N_TARG
);
	import xbar_pkg::*;

	logic [N_TARG-1:0] req;
	logic [N_TARG-1:0] gnt;
	addr_t addr;
	len_t len;
	id_out_t id;

	modport init (
		output req,
		output addr,
		output len,
		output id,
		input gnt
	);

	modport targ (
		input req,
		input addr,
		input len,
		input id,
		output gnt
	);

endinterface

// Read data from one target towards all initiators.
interface r_route_if #(
	parameter int N_INIT = xbar_pkg::N_INIT
);
	import xbar_pkg::*;

	logic [N_INIT-1:0] valid;
	logic [N_INIT-1:0] ready;
	data_t data;
	resp_t resp;
	logic last;
	id_in_t id;

	modport targ (
		output valid,
		output data,
		output resp,
		output last,
		output id,
		input ready
	);

	modport init (
		input valid,
		input data,
		input resp,
		input last,
		input id,
		output ready
	);

endinterface

//--- xbar_pkg.sv
package xbar_pkg;

	// Port counts of the node.
	localparam int N_INIT = 2;
	localparam int N_TARG = 2;
	localparam int N_REGION = 2;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int LEN_W = 8;
	localparam int RESP_W = 2;
	localparam int ID_IN_W = 4;

	// Initiator index bits, prepended to the ID on the target side.
	localparam int IDX_W = $clog2(N_INIT);
	localparam int ID_OUT_W = ID_IN_W + IDX_W;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [LEN_W-1:0] len_t;
	typedef logic [ID_IN_W-1:0] id_in_t;
	typedef logic [ID_OUT_W-1:0] id_out_t;
	typedef logic [RESP_W-1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_DECERR = 2'b11;

endpackage
